// File: design/link_pkg.sv
// Shared types and constants for the scrambled word link.
package link_pkg;

    // ********************************************************************
    // Data types
    // ********************************************************************

    localparam int WORD_WIDTH = 32; // Width of one link word and of the LFSR.

    // One word of link data as it travels through the FIFOs and handshakes.
    typedef logic [WORD_WIDTH-1:0] word_t;

    // State of the keystream generator.
    typedef logic [WORD_WIDTH-1:0] lfsr_t;

    // ********************************************************************
    // Keystream constants
    // ********************************************************************

    // Galois feedback mask, applied when the bit shifted out is a one.
    localparam lfsr_t SCRAMBLE_POLY = 32'h8020_0003;

    // State after reset. It must be non-zero or the LFSR locks up.
    localparam lfsr_t SCRAMBLE_SEED = 32'hace1_0001;

    // ********************************************************************
    // Default buffer sizes
    // ********************************************************************

    localparam int IN_DEPTH_DEFAULT  = 8; // Entries in the input FIFO.
    localparam int OUT_DEPTH_DEFAULT = 4; // Entries in the output FIFO.

endpackage : link_pkg

// File: design/synchronous_buffer.sv
`ifndef SYNCHRONOUS_BUFFER_SV
`define SYNCHRONOUS_BUFFER_SV

`timescale 1ns/10ps

module synchronous_buffer #(
    parameter int BUFFER_DEPTH           = 8,  // Entries, a power of two, at least 2.
    parameter int DATA_WIDTH             = 32, // Bits per entry.
    parameter int FIRST_WORD_FALL_TROUGH = 0   // 1 shows the head entry without a read delay.
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  write_i,      // Push one entry, only while not full.
    input  logic                  read_i,       // Pop one entry, only while not empty.
    input  logic [DATA_WIDTH-1:0] write_data_i,
    output logic [DATA_WIDTH-1:0] read_data_o,
    output logic                  empty_o,
    output logic                  full_o
);

    localparam int PTR_W = $clog2(BUFFER_DEPTH); // Pointers wrap naturally at the depth.

    // Push and pull codes for the {write_i, read_i} pair.
    localparam logic [1:0] OP_PULL = 2'b01;
    localparam logic [1:0] OP_PUSH = 2'b10;

    logic [DATA_WIDTH-1:0] mem [BUFFER_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [PTR_W-1:0]      wr_ptr_next; // Write pointer after one push.
    logic [PTR_W-1:0]      rd_ptr_next; // Read pointer after one pop.

    // The pointer arithmetic only works for a power-of-two depth.
    if (BUFFER_DEPTH < 2 || (BUFFER_DEPTH & (BUFFER_DEPTH - 1)) != 0) begin : g_depth_check
        $error("synchronous_buffer: BUFFER_DEPTH must be a power of two and at least 2.");
    end

    // ********************************************************************
    // Storage
    // ********************************************************************

    always_ff @(posedge clk_i) begin
        if (write_i) begin
            mem[wr_ptr] <= write_data_i; // Store at the tail.
        end
    end

    if (FIRST_WORD_FALL_TROUGH == 0) begin : g_registered_read
        // The popped entry appears on the cycle after the read pulse.
        always_ff @(posedge clk_i) begin
            if (read_i) begin
                read_data_o <= mem[rd_ptr];
            end
        end
    end else begin : g_fall_through_read
        assign read_data_o = mem[rd_ptr]; // Head entry is always visible.
    end

    // ********************************************************************
    // Pointers and status flags
    // ********************************************************************

    assign wr_ptr_next = wr_ptr + 1'b1;
    assign rd_ptr_next = rd_ptr + 1'b1;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            empty_o <= 1'b1;
            full_o  <= 1'b0;
        end else begin
            if (write_i) wr_ptr <= wr_ptr_next;
            if (read_i)  rd_ptr <= rd_ptr_next;
            // A simultaneous push and pop leaves the fill level, and so both flags, unchanged.
            case ({write_i, read_i})
                OP_PULL: begin
                    full_o  <= 1'b0;
                    empty_o <= (rd_ptr_next == wr_ptr); // Last entry just left.
                end
                OP_PUSH: begin
                    empty_o <= 1'b0;
                    full_o  <= (wr_ptr_next == rd_ptr); // Tail caught up with the head.
                end
                default: ;
            endcase
        end
    end

    // Writers and readers must respect the flags, otherwise entries are lost or repeated.
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        write_i |-> !full_o) else $error("FIFO written while full.");
    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        read_i |-> !empty_o) else $error("FIFO read while empty.");

endmodule : synchronous_buffer

`endif

// File: design/handshake_receiver.sv
`timescale 1ns/10ps

// Four-phase sink on the producer side of the link.
module handshake_receiver (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           in_req_i,     // Producer request, data valid while high.
    input  link_pkg::word_t in_data_i,
    input  logic           fifo_full_i,  // Input FIFO cannot take a word.
    output logic           in_ack_o,     // Acknowledge back to the producer.
    output logic           fifo_write_o, // One-cycle push into the input FIFO.
    output link_pkg::word_t fifo_data_o
);

    typedef enum logic [1:0] {
        RX_IDLE,    // Ack low, waiting for a request.
        RX_ACK,     // Ack high, waiting for the request to drop.
        RX_RELEASE  // Ack has just fallen; one recovery cycle.
    } rx_state_t;

    rx_state_t state_q;
    rx_state_t state_d;

    // ********************************************************************
    // Handshake FSM
    // ********************************************************************

    always_comb begin
        state_d      = state_q;
        fifo_write_o = 1'b0;
        case (state_q)
            RX_IDLE: begin
                // A full FIFO holds the request off with no ack and no write.
                if (in_req_i && !fifo_full_i) begin
                    fifo_write_o = 1'b1; // Capture on the first cycle the request is seen.
                    state_d      = RX_ACK;
                end
            end
            RX_ACK: begin
                if (!in_req_i) state_d = RX_RELEASE; // Producer finished phase 3.
            end
            RX_RELEASE: state_d = RX_IDLE;
            default:    state_d = RX_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= RX_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Ack follows the state register, so it rises the cycle after the write
    // and falls the cycle after the request is seen low.
    assign in_ack_o    = (state_q == RX_ACK);
    assign fifo_data_o = in_data_i; // Data is stable for the whole request.

    // Back-pressure must reach the write strobe.
    a_no_write_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fifo_write_o |-> !fifo_full_i) else $error("Receiver wrote into a full FIFO.");

endmodule : handshake_receiver

// File: design/word_scrambler.sv
`timescale 1ns/10ps

// Moves one word at a time from the input FIFO to the output FIFO and
// XORs it with a Galois LFSR keystream.
module word_scrambler (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           src_empty_i, // Input FIFO has nothing to pop.
    input  link_pkg::word_t src_data_i,  // Registered read data of the input FIFO.
    input  logic           dst_full_i,  // Output FIFO cannot take a word.
    output logic           src_read_o,  // One-cycle pop from the input FIFO.
    output logic           dst_write_o, // One-cycle push into the output FIFO.
    output link_pkg::word_t dst_data_o   // Scrambled word held for the push.
);

    import link_pkg::*;

    typedef enum logic [1:0] {
        SC_POP,     // Issue a pop as soon as a word is waiting.
        SC_CAPTURE, // Read data is valid this cycle.
        SC_PUSH     // Hold the scrambled word until the output FIFO has room.
    } sc_state_t;

    sc_state_t state_q;
    sc_state_t state_d;
    lfsr_t     lfsr_q;  // Current keystream word.

    // One Galois step. Shift right and fold the polynomial in when a one falls out.
    function automatic lfsr_t lfsr_step(input lfsr_t state);
        lfsr_t shifted;
        shifted = state >> 1;
        return state[0] ? (shifted ^ SCRAMBLE_POLY) : shifted;
    endfunction

    // ********************************************************************
    // Transfer FSM
    // ********************************************************************

    always_comb begin
        state_d     = state_q;
        src_read_o  = 1'b0;
        dst_write_o = 1'b0;
        case (state_q)
            SC_POP: begin
                if (!src_empty_i) begin
                    src_read_o = 1'b1;
                    state_d    = SC_CAPTURE; // Data arrives one cycle later.
                end
            end
            SC_CAPTURE: state_d = SC_PUSH;
            SC_PUSH: begin
                if (!dst_full_i) begin
                    dst_write_o = 1'b1;
                    state_d     = SC_POP;
                end
            end
            default: state_d = SC_POP;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= SC_POP;
            lfsr_q  <= SCRAMBLE_SEED;
        end else begin
            state_q <= state_d;
            if (state_q == SC_CAPTURE) begin
                lfsr_q <= lfsr_step(lfsr_q); // Exactly one step per word.
            end
        end
    end

    // Payload register for the word in flight.
    always_ff @(posedge clk_i) begin
        if (state_q == SC_CAPTURE) begin
            dst_data_o <= src_data_i ^ lfsr_q;
        end
    end

    // A zero state would never leave zero and the keystream would vanish.
    a_lfsr_nonzero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        lfsr_q != '0) else $error("LFSR reached the all-zero state.");

endmodule : word_scrambler

// File: design/handshake_transmitter.sv
`timescale 1ns/10ps

// Four-phase source on the consumer side of the link.
module handshake_transmitter (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           fifo_empty_i, // Output FIFO has nothing to pop.
    input  link_pkg::word_t fifo_data_i,  // Registered read data of the output FIFO.
    input  logic           out_ack_i,    // Consumer acknowledge.
    output logic           fifo_read_o,  // One-cycle pop from the output FIFO.
    output logic           out_req_o,    // Request towards the consumer.
    output link_pkg::word_t out_data_o
);

    typedef enum logic [1:0] {
        TX_IDLE,     // Pop the next word when one is available.
        TX_LOAD,     // Popped word is on the FIFO read port.
        TX_REQ,      // Request high, waiting for the ack.
        TX_WAIT_LOW  // Request dropped, waiting for the ack to fall.
    } tx_state_t;

    tx_state_t state_q;
    tx_state_t state_d;

    // ********************************************************************
    // Handshake FSM
    // ********************************************************************

    always_comb begin
        state_d     = state_q;
        fifo_read_o = 1'b0;
        case (state_q)
            TX_IDLE: begin
                if (!fifo_empty_i) begin
                    fifo_read_o = 1'b1;
                    state_d     = TX_LOAD;
                end
            end
            TX_LOAD:     state_d = TX_REQ;
            TX_REQ:      if (out_ack_i)  state_d = TX_WAIT_LOW; // Phase 2 seen.
            TX_WAIT_LOW: if (!out_ack_i) state_d = TX_IDLE;     // Phase 4 seen.
            default:     state_d = TX_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= TX_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // The word is latched as the request goes up and stays put until the next load.
    always_ff @(posedge clk_i) begin
        if (state_q == TX_LOAD) begin
            out_data_o <= fifo_data_i;
        end
    end

    assign out_req_o = (state_q == TX_REQ); // Falls the cycle after the ack is seen.

    // Data must not move under a raised request.
    a_data_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_req_o && $past(out_req_o) |-> $stable(out_data_o))
        else $error("out_data_o changed while out_req_o was high.");
    // A new request waits for the previous ack to fall.
    a_req_after_ack_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(out_req_o) |-> !$past(out_ack_i))
        else $error("out_req_o rose while out_ack_i was still high.");

endmodule : handshake_transmitter

// File: design/scrambler_link_top.sv
`timescale 1ns/10ps

// Scrambled word link: receiver, input FIFO, scrambler, output FIFO, transmitter.
module scrambler_link_top #(
    parameter int IN_DEPTH  = link_pkg::IN_DEPTH_DEFAULT,  // Input FIFO entries.
    parameter int OUT_DEPTH = link_pkg::OUT_DEPTH_DEFAULT  // Output FIFO entries.
) (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           in_req_i,
    input  link_pkg::word_t in_data_i,
    output logic           in_ack_o,
    output logic           out_req_o,
    output link_pkg::word_t out_data_o,
    input  logic           out_ack_i
);

    import link_pkg::*;

    // Input FIFO wiring.
    logic  in_fifo_write;
    logic  in_fifo_read;
    logic  in_fifo_full;
    logic  in_fifo_empty;
    word_t in_fifo_wdata;
    word_t in_fifo_rdata;

    // Output FIFO wiring.
    logic  out_fifo_write;
    logic  out_fifo_read;
    logic  out_fifo_full;
    logic  out_fifo_empty;
    word_t out_fifo_wdata;
    word_t out_fifo_rdata;

    // ********************************************************************
    // Input side
    // ********************************************************************

    handshake_receiver i_receiver (
        .clk_i, .rst_n_i, .in_req_i, .in_data_i,
        .fifo_full_i  (in_fifo_full),
        .in_ack_o,
        .fifo_write_o (in_fifo_write),
        .fifo_data_o  (in_fifo_wdata)
    );

    synchronous_buffer #(
        .BUFFER_DEPTH (IN_DEPTH), .DATA_WIDTH ($bits(word_t)), .FIRST_WORD_FALL_TROUGH (0)
    ) i_in_fifo (
        .clk_i, .rst_n_i,
        .write_i (in_fifo_write), .read_i (in_fifo_read),
        .write_data_i (in_fifo_wdata), .read_data_o (in_fifo_rdata),
        .empty_o (in_fifo_empty), .full_o (in_fifo_full)
    );

    // ********************************************************************
    // Processing and output side
    // ********************************************************************

    word_scrambler i_scrambler (
        .clk_i, .rst_n_i,
        .src_empty_i (in_fifo_empty), .src_data_i (in_fifo_rdata), .dst_full_i (out_fifo_full),
        .src_read_o (in_fifo_read), .dst_write_o (out_fifo_write), .dst_data_o (out_fifo_wdata)
    );

    synchronous_buffer #(
        .BUFFER_DEPTH (OUT_DEPTH), .DATA_WIDTH ($bits(word_t)), .FIRST_WORD_FALL_TROUGH (0)
    ) i_out_fifo (
        .clk_i, .rst_n_i,
        .write_i (out_fifo_write), .read_i (out_fifo_read),
        .write_data_i (out_fifo_wdata), .read_data_o (out_fifo_rdata),
        .empty_o (out_fifo_empty), .full_o (out_fifo_full)
    );

    handshake_transmitter i_transmitter (
        .clk_i, .rst_n_i,
        .fifo_empty_i (out_fifo_empty), .fifo_data_i (out_fifo_rdata), .out_ack_i,
        .fifo_read_o (out_fifo_read), .out_req_o, .out_data_o
    );

endmodule : scrambler_link_top

// File: tests/scrambler_link_tb.sv
`timescale 1ns/10ps

// Random producer and consumer around the scrambled word link, with a
// keystream model and protocol monitors on both handshake channels.
module scrambler_link_tb;

    import link_pkg::*;

    localparam int N_WORDS       = 300;   // Words pushed through the link.
    localparam int CLK_PERIOD    = 8;     // Clock period in ns.
    localparam int RESET_CYCLES  = 8;     // Cycles with rst_n_i held low.
    localparam int STALL_EVERY   = 50;    // Consumer stalls after this many words.
    localparam int STALL_CYCLES  = 40;    // Length of one consumer stall.
    localparam int PENDING_LIMIT = 8;     // A longer wait for ack counts as back-pressure.
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_WORDS * 40
                                    + (N_WORDS / STALL_EVERY) * STALL_CYCLES;

    logic  clk_i;
    logic  rst_n_i;
    logic  in_req;   // Producer request.
    word_t in_data;
    logic  in_ack;
    logic  out_req;  // Request towards the consumer.
    word_t out_data;
    logic  out_ack;  // Consumer acknowledge.

    word_t expected_q[$];   // Scrambled words in the order they must leave.
    lfsr_t model_lfsr;      // Keystream state of the reference model.
    int    words_sent;      // Completed input handshakes.
    int    words_received;  // Completed output handshakes.
    int    ack_pulses;      // Rising edges of in_ack_o seen by the monitor.
    bit    backpressure_seen;
    bit    in_full_seen;
    bit    out_full_seen;

    // Values from the previous monitor sample, for edge detection.
    logic  prev_in_req;
    logic  prev_in_ack;
    logic  prev_out_req;
    logic  prev_out_ack;
    word_t prev_out_data;

    scrambler_link_top #(
        .IN_DEPTH  (IN_DEPTH_DEFAULT),
        .OUT_DEPTH (OUT_DEPTH_DEFAULT)
    ) i_dut (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .in_req_i   (in_req),
        .in_data_i  (in_data),
        .in_ack_o   (in_ack),
        .out_req_o  (out_req),
        .out_data_o (out_data),
        .out_ack_i  (out_ack)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ********************************************************************
    // Reference model and helpers
    // ********************************************************************

    // Galois step. The state moves right and the mask folds in on a one out.
    function automatic lfsr_t advance_lfsr(input lfsr_t state);
        lfsr_t next;
        next = {1'b0, state[31:1]};
        if (state[0]) next = next ^ SCRAMBLE_POLY;
        return next;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Check failed.");
        end
    endtask

    // All stimulus changes 1 ns after the rising edge, where DUT outputs are settled.
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    // One four-phase transfer on the input channel.
    task automatic send_word(input word_t data);
        int waited;
        waited  = 0;
        in_data = data;
        in_req  = 1'b1;
        expected_q.push_back(data ^ model_lfsr); // Model scrambles in input order.
        model_lfsr = advance_lfsr(model_lfsr);
        do begin
            next_cycle();
            waited++;
        end while (!in_ack);
        if (waited > PENDING_LIMIT) backpressure_seen = 1'b1; // The link was full.
        in_req = 1'b0;
        do begin
            next_cycle();
        end while (in_ack);                      // Next word only after ack is low.
        words_sent++;
    endtask

    task automatic run_producer();
        int i;
        int gap;
        for (i = 0; i < N_WORDS; i++) begin
            send_word($urandom());
            gap = $urandom_range(5, 0);           // Idle cycles between words.
            repeat (gap) next_cycle();
        end
    endtask

    // One four-phase transfer on the output channel, checked against the model.
    task automatic receive_word();
        int    delay;
        int    hold;
        word_t expected;
        while (!out_req) next_cycle();
        delay = $urandom_range(9, 0);             // Consumer reaction time.
        repeat (delay) next_cycle();
        check_value(expected_q.size() != 0, 1'b1, "output word with no input word pending");
        expected = expected_q.pop_front();
        check_value(out_data, expected, $sformatf("output word %0d", words_received));
        out_ack = 1'b1;
        do begin
            next_cycle();
        end while (out_req);
        hold = $urandom_range(3, 0);              // The sink may keep ack up a little longer.
        repeat (hold) next_cycle();
        out_ack = 1'b0;
        words_received++;
    endtask

    task automatic run_consumer();
        int i;
        for (i = 0; i < N_WORDS; i++) begin
            receive_word();
            // A long stall lets both FIFOs fill up behind the transmitter.
            if (words_received % STALL_EVERY == 0) repeat (STALL_CYCLES) next_cycle();
        end
    endtask

    // ********************************************************************
    // Protocol monitors
    // ********************************************************************

    // Sampled on the falling edge, half a period away from any change.
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (in_ack && !prev_in_ack) begin
                check_value(prev_in_req, 1'b1, "in_ack_o rose without a request");
                ack_pulses++;
            end
            if (!in_ack && prev_in_ack) begin
                check_value(prev_in_req, 1'b0, "in_ack_o fell while in_req_i was high");
            end
            if (out_req && prev_out_req) begin
                check_value(out_data, prev_out_data, "out_data_o moved under out_req_o");
            end
            if (!out_req && prev_out_req) begin
                check_value(prev_out_ack, 1'b1, "out_req_o fell before out_ack_i");
            end
            if (out_req && !prev_out_req) begin
                // The ack of the previous word must have been low before the rise.
                check_value(prev_out_ack, 1'b0, "out_req_o rose with out_ack_i high");
                check_value(ack_pulses != 0, 1'b1, "out_req_o rose before any input word");
            end
            if (i_dut.in_fifo_full) in_full_seen = 1'b1;
            if (i_dut.out_fifo_full) out_full_seen = 1'b1;
        end
        prev_in_req   = in_req;
        prev_in_ack   = in_ack;
        prev_out_req  = out_req;
        prev_out_ack  = out_ack;
        prev_out_data = out_data;
    end

    // ********************************************************************
    // Watchdog and main sequence
    // ********************************************************************

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("Timeout: the link did not deliver %0d words within %0d cycles.",
                 N_WORDS, TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation timed out.");
    end

    initial begin
        rst_n_i           = 1'b0;
        in_req            = 1'b0;
        in_data           = '0;
        out_ack           = 1'b0;
        model_lfsr        = SCRAMBLE_SEED; // Same start as the DUT after reset.
        words_sent        = 0;
        words_received    = 0;
        ack_pulses        = 0;
        backpressure_seen = 1'b0;
        in_full_seen      = 1'b0;
        out_full_seen     = 1'b0;
        prev_in_req       = 1'b0;
        prev_in_ack       = 1'b0;
        prev_out_req      = 1'b0;
        prev_out_ack      = 1'b0;
        prev_out_data     = '0;
        void'($urandom(32'hcbad));
        repeat (RESET_CYCLES) begin
            next_cycle();
            check_value(in_ack, 1'b0, "in_ack_o during reset");
            check_value(out_req, 1'b0, "out_req_o during reset");
        end
        rst_n_i = 1'b1;
        repeat (4) begin
            next_cycle();                  // Idle link must stay quiet.
            check_value(in_ack, 1'b0, "in_ack_o after reset");
            check_value(out_req, 1'b0, "out_req_o after reset");
        end
        fork
            run_producer();
            run_consumer();
        join
        repeat (4) next_cycle();
        check_value(words_received, N_WORDS, "words received");
        check_value(words_sent, N_WORDS, "words sent");
        check_value(ack_pulses, words_sent, "input ack pulses");
        check_value(expected_q.size(), 0, "words left in the model queue");
        check_value(backpressure_seen, 1'b1, "request held off by a full link");
        check_value(in_full_seen, 1'b1, "input FIFO reached full");
        check_value(out_full_seen, 1'b1, "output FIFO reached full");
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule : scrambler_link_tb

// File: verilog.f
design/link_pkg.sv
design/synchronous_buffer.sv
design/handshake_receiver.sv
design/word_scrambler.sv
design/handshake_transmitter.sv
design/scrambler_link_top.sv
tests/scrambler_link_tb.sv

// File: Makefile
# Verilator build for the scrambled word link testbench.

TOP := scrambler_link_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/10ps -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f verilog.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
